/* decodePkg.sv */
package decodePkg;

    localparam int instW  = 32;
    localparam int lAddrW = 6;

    localparam logic [lAddrW-1:0] regLink = lAddrW'(31);
    localparam logic [lAddrW-1:0] regHi   = lAddrW'(32);   // above the general registers.
    localparam logic [lAddrW-1:0] regLo   = lAddrW'(33);

    typedef enum logic [5:0] {
        nopU, addU, adduU, subU, subuU, sltU, sltuU, addiU, addiuU, sltiU, sltiuU,
        andU, orU, xorU, norU, andiU, oriU, xoriU, luiU,
        sllU, srlU, sraU, sllvU, srlvU, sravU,
        multHiU, multLoU, multuHiU, multuLoU, divHiU, divLoU, divuHiU, divuLoU,
        mfhiU, mfloU, mthiU, mtloU,
        beqU, bneU, bgezU, bgtzU, blezU, bltzU, bgezalU, bltzalU,
        jU, jalU, jrU, jalrU,
        syscallU, breakU, reservedU
    } uopKind_t;

    typedef enum logic {unitAlu, unitMdu} unit_t;
    typedef enum logic [2:0] {
        aluArith, aluLogic, aluShift, aluBranch, aluMove, aluMisc
    } aluType_t;
    typedef enum logic [1:0] {brNone, brCond, brJump, brReg} branchType_t;
    typedef enum logic [1:0] {immSext, immZext, immLui, immShamt} immSel_t;
    typedef enum logic [2:0] {
        excNone, excSysCall, excBreak, excReserved, excAddrIF
    } exc_t;

    typedef struct packed {
        logic             valid;
        logic [instW-1:0] inst;
        logic [instW-1:0] pc;
        logic             badAddr;   // fetch address error.
    } fetchBundle_t;

    typedef struct packed {
        logic              valid;
        logic [instW-1:0]  pc;
        logic              badAddr;
        logic [instW-1:0]  inst;
        logic [lAddrW-1:0] rs;
        logic [lAddrW-1:0] rt;
        logic [lAddrW-1:0] rd;
        logic [15:0]       offset;
        logic [25:0]       jumpIdx;
        logic [instW-1:0]  immSext;
        logic [instW-1:0]  immZext;
        logic [instW-1:0]  immLui;
        logic [instW-1:0]  immShamt;
    } fields_t;

    typedef struct packed {
        logic              valid;
        logic [instW-1:0]  pc;
        logic              badAddr;
        logic [instW-1:0]  inst;
        logic [lAddrW-1:0] rs;
        logic [lAddrW-1:0] rt;
        logic [lAddrW-1:0] rd;
        logic [15:0]       offset;
        logic [25:0]       jumpIdx;
        uopKind_t          kind;
        logic              split;     // hi/lo pair.
        unit_t             unit;
        aluType_t          aluType;
        branchType_t       branchType;
        logic [lAddrW-1:0] op0Addr;
        logic [lAddrW-1:0] op1Addr;
        logic [lAddrW-1:0] dstAddr;
        logic              op0Re;
        logic              op1Re;
        logic              dstWe;
        immSel_t           immSel;
        exc_t              exc;
        logic [instW-1:0]  imm;
    } uopTemplate_t;

    typedef struct packed {
        logic              valid;
        uopKind_t          kind;
        unit_t             unit;
        aluType_t          aluType;
        logic [lAddrW-1:0] op0Addr;
        logic [lAddrW-1:0] op1Addr;
        logic [lAddrW-1:0] dstAddr;
        logic              op0Re;
        logic              op1Re;
        logic              dstWe;
        logic [instW-1:0]  imm;
        branchType_t       branchType;
        logic [instW-1:0]  branchAddr;
        logic [instW-1:0]  pc;
        logic              causeExc;
        exc_t              exc;
        logic [instW-1:0]  badVAddr;
    } uop_t;

endpackage

/* fieldSplit.sv */
`timescale 1ns/1ps

module fieldSplit import decodePkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  fetchBundle_t fetch,
    output fields_t      fields
);

    logic [instW-1:0] inst;
    fields_t          nxt;

    assign inst = fetch.inst;

    always_comb begin
        nxt.valid    = fetch.valid;
        nxt.pc       = fetch.pc;
        nxt.badAddr  = fetch.badAddr;
        nxt.inst     = inst;
        nxt.rs       = lAddrW'(inst[25:21]);
        nxt.rt       = lAddrW'(inst[20:16]);
        nxt.rd       = lAddrW'(inst[15:11]);
        nxt.offset   = inst[15:0];
        nxt.jumpIdx  = inst[25:0];
        // decode picks one of these four immediates.
        nxt.immSext  = {{16{inst[15]}}, inst[15:0]};
        nxt.immZext  = {16'h0000, inst[15:0]};
        nxt.immLui   = {inst[15:0], 16'h0000};
        nxt.immShamt = {27'h0, inst[10:6]};
    end

    always_ff @(posedge clk) begin
        fields <= nxt;
        if (!rstN) begin
            fields.valid <= 1'b0;
        end
    end

endmodule

/* opDecode.sv */
`timescale 1ns/1ps

module opDecode import decodePkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  fields_t      fields,
    output uopTemplate_t tmpl
);

    logic [5:0]   opcode;
    logic [5:0]   funct;
    uopKind_t     kind;
    uopTemplate_t nxt;

    assign opcode = fields.inst[31:26];
    assign funct  = fields.inst[5:0];

    // encoding to kind.
    always_comb begin
        kind = reservedU;
        if (fields.inst == '0) begin
            kind = nopU;
        end else begin
            case (opcode)
                6'h00: begin
                    case (funct)
                        6'h00: kind = sllU;
                        6'h02: kind = srlU;
                        6'h03: kind = sraU;
                        6'h04: kind = sllvU;
                        6'h06: kind = srlvU;
                        6'h07: kind = sravU;
                        6'h08: kind = jrU;
                        6'h09: kind = jalrU;
                        6'h0c: kind = syscallU;
                        6'h0d: kind = breakU;
                        6'h10: kind = mfhiU;
                        6'h11: kind = mthiU;
                        6'h12: kind = mfloU;
                        6'h13: kind = mtloU;
                        6'h18: kind = multHiU;
                        6'h19: kind = multuHiU;
                        6'h1a: kind = divHiU;
                        6'h1b: kind = divuHiU;
                        6'h20: kind = addU;
                        6'h21: kind = adduU;
                        6'h22: kind = subU;
                        6'h23: kind = subuU;
                        6'h24: kind = andU;
                        6'h25: kind = orU;
                        6'h26: kind = xorU;
                        6'h27: kind = norU;
                        6'h2a: kind = sltU;
                        6'h2b: kind = sltuU;
                        default: kind = reservedU;
                    endcase
                end
                6'h01: begin   // regimm selects on rt.
                    case (fields.rt)
                        6'h00: kind = bltzU;
                        6'h01: kind = bgezU;
                        6'h10: kind = bltzalU;
                        6'h11: kind = bgezalU;
                        default: kind = reservedU;
                    endcase
                end
                6'h02: kind = jU;
                6'h03: kind = jalU;
                6'h04: kind = beqU;
                6'h05: kind = bneU;
                6'h06: kind = blezU;
                6'h07: kind = bgtzU;
                6'h08: kind = addiU;
                6'h09: kind = addiuU;
                6'h0a: kind = sltiU;
                6'h0b: kind = sltiuU;
                6'h0c: kind = andiU;
                6'h0d: kind = oriU;
                6'h0e: kind = xoriU;
                6'h0f: kind = luiU;
                default: kind = reservedU;
            endcase
        end
    end

    always_comb begin
        nxt.valid      = fields.valid && (kind != nopU);
        nxt.pc         = fields.pc;
        nxt.badAddr    = fields.badAddr;
        nxt.inst       = fields.inst;
        nxt.rs         = fields.rs;
        nxt.rt         = fields.rt;
        nxt.rd         = fields.rd;
        nxt.offset     = fields.offset;
        nxt.jumpIdx    = fields.jumpIdx;
        nxt.kind       = kind;
        nxt.split      = 1'b0;
        nxt.unit       = unitAlu;
        nxt.aluType    = aluMisc;
        nxt.branchType = brNone;
        nxt.op0Addr    = fields.rs;
        nxt.op1Addr    = fields.rt;
        nxt.dstAddr    = fields.rd;
        nxt.op0Re      = 1'b0;
        nxt.op1Re      = 1'b0;
        nxt.dstWe      = 1'b0;
        nxt.immSel     = immSext;
        nxt.exc        = excNone;
        case (kind)
            addU, adduU, subU, subuU, sltU, sltuU, andU, orU, xorU, norU: begin
                nxt.aluType = (kind inside {andU, orU, xorU, norU}) ? aluLogic : aluArith;
                nxt.op0Re   = 1'b1;
                nxt.op1Re   = 1'b1;
                nxt.dstWe   = 1'b1;
            end
            addiU, addiuU, sltiU, sltiuU, andiU, oriU, xoriU, luiU: begin
                nxt.aluType = (kind inside {addiU, addiuU, sltiU, sltiuU}) ? aluArith : aluLogic;
                nxt.dstAddr = fields.rt;
                nxt.op0Re   = (kind != luiU);
                nxt.dstWe   = 1'b1;
                if (kind == luiU) nxt.immSel = immLui;
                else if (nxt.aluType == aluLogic) nxt.immSel = immZext;
            end
            sllU, srlU, sraU, sllvU, srlvU, sravU: begin
                nxt.aluType = aluShift;
                nxt.op0Addr = fields.rt;   // value being shifted.
                nxt.op1Addr = fields.rs;
                nxt.op0Re   = 1'b1;
                nxt.op1Re   = (kind inside {sllvU, srlvU, sravU});
                nxt.dstWe   = 1'b1;
                nxt.immSel  = immShamt;
            end
            multHiU, multuHiU, divHiU, divuHiU: begin
                nxt.unit    = unitMdu;
                nxt.split   = 1'b1;
                nxt.dstAddr = regHi;       // lo half is added in uopForm.
                nxt.op0Re   = 1'b1;
                nxt.op1Re   = 1'b1;
                nxt.dstWe   = 1'b1;
            end
            mfhiU, mfloU, mthiU, mtloU: begin
                nxt.aluType = aluMove;
                if (kind == mfhiU) nxt.op0Addr = regHi;
                if (kind == mfloU) nxt.op0Addr = regLo;
                if (kind == mthiU) nxt.dstAddr = regHi;
                if (kind == mtloU) nxt.dstAddr = regLo;
                nxt.op0Re   = 1'b1;
                nxt.dstWe   = 1'b1;
            end
            beqU, bneU, bgezU, bgtzU, blezU, bltzU, bgezalU, bltzalU: begin
                nxt.aluType    = aluBranch;
                nxt.branchType = brCond;
                nxt.dstAddr    = regLink;
                nxt.op0Re      = 1'b1;
                nxt.op1Re      = (kind == beqU) || (kind == bneU);
                nxt.dstWe      = (kind == bgezalU) || (kind == bltzalU);
            end
            jU, jalU: begin
                nxt.aluType    = aluBranch;
                nxt.branchType = brJump;
                nxt.dstAddr    = regLink;
                nxt.dstWe      = (kind == jalU);
            end
            jrU, jalrU: begin
                nxt.aluType    = aluBranch;
                nxt.branchType = brReg;
                nxt.op0Re      = 1'b1;
                nxt.dstWe      = (kind == jalrU);
            end
            syscallU: nxt.exc = excSysCall;
            breakU:   nxt.exc = excBreak;
            reservedU: nxt.exc = excReserved;
            default: ;
        endcase
        // unused ports carry no address.
        if (!nxt.op0Re) nxt.op0Addr = '0;
        if (!nxt.op1Re) nxt.op1Addr = '0;
        if (!nxt.dstWe) nxt.dstAddr = '0;
        case (nxt.immSel)
            immZext:  nxt.imm = fields.immZext;
            immLui:   nxt.imm = fields.immLui;
            immShamt: nxt.imm = fields.immShamt;
            default:  nxt.imm = fields.immSext;
        endcase
    end

    always_ff @(posedge clk) begin
        tmpl <= nxt;
        if (!rstN) begin
            tmpl.valid <= 1'b0;
        end
    end

endmodule

/* uopForm.sv */
`timescale 1ns/1ps

module uopForm import decodePkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  uopTemplate_t tmpl,
    output uop_t         uop0,
    output uop_t         uop1
);

    uop_t             nxt0;
    uop_t             nxt1;
    logic [instW-1:0] offsetW;

    assign offsetW = {{14{tmpl.offset[15]}}, tmpl.offset, 2'b00};   // word offset.

    always_comb begin
        nxt0.valid      = tmpl.valid;
        nxt0.kind       = tmpl.kind;
        nxt0.unit       = tmpl.unit;
        nxt0.aluType    = tmpl.aluType;
        nxt0.op0Addr    = tmpl.op0Addr;
        nxt0.op1Addr    = tmpl.op1Addr;
        nxt0.dstAddr    = tmpl.dstAddr;
        nxt0.op0Re      = tmpl.op0Re;
        nxt0.op1Re      = tmpl.op1Re;
        nxt0.dstWe      = tmpl.dstWe;
        nxt0.imm        = tmpl.imm;
        nxt0.branchType = tmpl.branchType;
        nxt0.pc         = tmpl.pc;
        case (tmpl.branchType)
            brCond:  nxt0.branchAddr = tmpl.pc + offsetW;
            brJump:  nxt0.branchAddr = {tmpl.pc[instW-1 -: 4], tmpl.jumpIdx, 2'b00};
            default: nxt0.branchAddr = '0;   // jr target comes from a register.
        endcase

        // fetch fault wins over whatever the table found.
        if (tmpl.badAddr) begin
            nxt0.exc      = excAddrIF;
            nxt0.badVAddr = tmpl.pc;
        end else begin
            nxt0.exc      = tmpl.exc;
            nxt0.badVAddr = '0;
        end
        nxt0.causeExc = (nxt0.exc != excNone);

        nxt1         = nxt0;
        nxt1.valid   = tmpl.valid && tmpl.split;
        nxt1.dstAddr = regLo;
        case (tmpl.kind)
            multHiU:  nxt1.kind = multLoU;
            multuHiU: nxt1.kind = multuLoU;
            divHiU:   nxt1.kind = divLoU;
            divuHiU:  nxt1.kind = divuLoU;
            default:  nxt1.kind = nopU;
        endcase
    end

    always_ff @(posedge clk) begin
        uop0 <= nxt0;
        uop1 <= nxt1;
        if (!rstN) begin
            uop0.valid <= 1'b0;
            uop1.valid <= 1'b0;
        end
    end

endmodule

/* decodeTop.sv */
`timescale 1ns/1ps

module decodeTop import decodePkg::*; (
    input  logic         clk,
    input  logic         rstN,
    input  fetchBundle_t fetch,
    output uop_t         uop0,
    output uop_t         uop1
);

    fields_t      fields;
    uopTemplate_t tmpl;

    // three register stages from fetch to uops.
    fieldSplit fieldSplit0 (
        .clk    (clk),
        .rstN   (rstN),
        .fetch  (fetch),
        .fields (fields)
    );

    opDecode opDecode0 (
        .clk    (clk),
        .rstN   (rstN),
        .fields (fields),
        .tmpl   (tmpl)
    );

    uopForm uopForm0 (
        .clk  (clk),
        .rstN (rstN),
        .tmpl (tmpl),
        .uop0 (uop0),
        .uop1 (uop1)
    );

endmodule

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rstN
);

    initial begin
        clk  = 1'b0;
        rstN = 1'b0;
        repeat (3) @(posedge clk);
        #2 rstN = 1'b1;   // low for three edges.
    end

    always #20 clk = ~clk;   // 40 ns period.

endmodule

/* decodeTb.sv */
`timescale 1ns/1ps

module decodeTb import decodePkg::*; ();

    localparam int vecW   = 11;   // words per vector line.
    localparam int maxVec = 64;

    logic         clk;
    logic         rstN;
    fetchBundle_t fetch;
    uop_t         uop0;
    uop_t         uop1;

    logic [31:0] vecMem [0:vecW*maxVec];
    int          nVec;
    int          pending[$];   // in flight with -1 for an idle cycle.
    logic [31:0] seed;
    int          errCount;
    int          testCount;
    int          passCount;
    string       tag;

    tbClock clkGen0 (
        .clk  (clk),
        .rstN (rstN)
    );

    decodeTop dut0 (
        .clk   (clk),
        .rstN  (rstN),
        .fetch (fetch),
        .uop0  (uop0),
        .uop1  (uop1)
    );

    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            errCount++;
            $display("ERR %0t: %s %s got %h expected %h", $time, tag, what, got, exp);
        end
    endtask

    task automatic checkIdle(input string what);
        tag = what;
        checkEq("uop0.valid", 32'(uop0.valid), 32'h0);
        checkEq("uop1.valid", 32'(uop1.valid), 32'h0);
    endtask

    task automatic checkVector(input int entry);
        int          b;
        int          errBefore;
        logic [31:0] pcExp;
        logic [31:0] excExp;
        b         = 1 + (entry % 256) * vecW;
        errBefore = errCount;
        pcExp     = vecMem[b+1];
        excExp    = vecMem[b+8];
        tag       = $sformatf("pass %0d vector %0d", entry / 256, entry % 256);
        checkEq("uop0.valid", 32'(uop0.valid), vecMem[b+3]);
        if (vecMem[b+3][0]) begin
            checkEq("uop0.kind", 32'(uop0.kind), vecMem[b+4]);
            checkEq("uop0.dstAddr", 32'(uop0.dstAddr), vecMem[b+5]);
            checkEq("uop0.imm", uop0.imm, vecMem[b+6]);
            checkEq("uop0.branchAddr", uop0.branchAddr, vecMem[b+7]);
            checkEq("uop0.exc", 32'(uop0.exc), excExp);
            checkEq("uop0.causeExc", 32'(uop0.causeExc), 32'(excExp != 0));
            checkEq("uop0.badVAddr", uop0.badVAddr, vecMem[b+2][0] ? pcExp : 32'h0);
            checkEq("uop0.pc", uop0.pc, pcExp);
        end
        checkEq("uop1.valid", 32'(uop1.valid), vecMem[b+9]);
        if (vecMem[b+9][0]) begin
            checkEq("uop1.kind", 32'(uop1.kind), vecMem[b+10]);
            checkEq("uop1.dstAddr", 32'(uop1.dstAddr), 32'(regLo));
            checkEq("uop1.pc", uop1.pc, pcExp);
        end
        testCount++;
        if (errCount == errBefore) passCount++;
        $display("%s inst %h: %s", tag, vecMem[b], (errCount == errBefore) ? "ok" : "FAILED");
    endtask

    // checks the result from three cycles back before driving.
    task automatic driveCycle(input int entry);
        int old;
        int b;
        @(posedge clk);
        #2;
        if (pending.size() == 3) begin
            old = pending.pop_front();
            if (old < 0) checkIdle("idle");
            else checkVector(old);
        end
        fetch = '0;
        if (entry >= 0) begin
            b             = 1 + (entry % 256) * vecW;
            fetch.valid   = 1'b1;
            fetch.inst    = vecMem[b];
            fetch.pc      = vecMem[b+1];
            fetch.badAddr = vecMem[b+2][0];
        end
        pending.push_back(entry);
    endtask

    task automatic runAll();
        int idle;
        int errBefore;
        errBefore = errCount;
        repeat (3) begin
            @(posedge clk);
            #2;
            checkIdle("reset");
        end
        testCount++;
        if (errCount == errBefore) passCount++;
        $display("reset: %s", (errCount == errBefore) ? "ok" : "FAILED");
        repeat (3) pending.push_back(-1);   // fetch held idle during reset.
        for (int v = 0; v < nVec; v++) begin
            driveCycle(256 + v);
            seed = lcgNext(seed);
            idle = int'(seed[31:30]);
            repeat (idle) driveCycle(-1);
        end
        // second pass back to back.
        for (int v = 0; v < nVec; v++) begin
            driveCycle(512 + v);
        end
        repeat (3) driveCycle(-1);
    endtask

    initial begin : mainFlow
        fetch     = '0;
        errCount  = 0;
        testCount = 0;
        passCount = 0;
        nVec      = 0;
        seed      = 32'hafa7cc06;
        $readmemh("decodeInput.txt", vecMem);
        if ($isunknown(vecMem[0]) || vecMem[0] == 0 || vecMem[0] > maxVec) begin
            $display("could not read a valid vector count from decodeInput.txt");
            $display("ERRORS FOUND");
            $finish;
        end else begin
            nVec = int'(vecMem[0]);
            runAll();
            $display("tests %0d, passed %0d, failed %0d, mismatches %0d",
                     testCount, passCount, testCount - passCount, errCount);
            if (errCount == 0) begin
                $display("NO ERRORS");
            end else begin
                $display("ERRORS FOUND");
            end
            $finish;
        end
    end

    initial begin : watchdog
        wait (nVec > 0);
        repeat (8 * nVec + 50) @(posedge clk);
        $display("timeout: the run did not finish within %0d cycles", 8 * nVec + 50);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* decodeInput.txt */
// vector count, then per line: inst pc badAddr, expected uop0 valid kind dstAddr imm
// branchAddr exc, expected uop1 valid kind (all hex)
1b
00221820 00400000 0 1 01 03 00001820 00000000 0 0 00
2085fffc 00400004 0 1 07 05 fffffffc 00000000 0 0 00
30e68001 00400008 0 1 0f 06 00008001 00000000 0 0 00
3408f0f0 0040000c 0 1 10 08 0000f0f0 00000000 0 0 00
3c091234 00400010 0 1 12 09 12340000 00000000 0 0 00
000b5140 00400014 0 1 13 0a 00000005 00000000 0 0 00
01cd6007 00400018 0 1 18 0c 00000000 00000000 0 0 00
00000000 0040001c 0 0 00 00 00000000 00000000 0 0 00
00220018 00400020 0 1 19 20 00000018 00000000 0 1 1a
0064001b 00400024 0 1 1f 20 0000001b 00000000 0 1 20
00a60019 00400028 0 1 1b 20 00000019 00000000 0 1 1c
00e8001a 0040002c 0 1 1d 20 0000001a 00000000 0 1 1e
00001010 00400030 0 1 21 02 00001010 00000000 0 0 00
00800013 00400034 0 1 24 21 00000013 00000000 0 0 00
10220003 00400100 0 1 25 00 00000003 0040010c 0 0 00
1460fffe 00400200 0 1 26 00 fffffffe 004001f8 0 0 00
04b00010 00400300 0 1 2c 1f 00000010 00400340 0 0 00
04d1ffff 00400400 0 1 2b 1f ffffffff 004003fc 0 0 00
08100040 90001000 0 1 2d 00 00000040 90400100 0 0 00
0fffffff 00400500 0 1 2e 1f ffffffff 0ffffffc 0 0 00
03e00008 00400600 0 1 2f 00 00000008 00000000 0 0 00
00a02009 00400604 0 1 30 04 00002009 00000000 0 0 00
0000000c 00400608 0 1 31 00 0000000c 00000000 1 0 00
0000000d 0040060c 0 1 32 00 0000000d 00000000 2 0 00
fc000000 00400610 0 1 33 00 00000000 00000000 3 0 00
00221820 00400003 1 1 01 03 00001820 00000000 4 0 00
00220018 00400006 1 1 19 20 00000018 00000000 4 1 1a

/* build.f */
decodePkg.sv
fieldSplit.sv
opDecode.sv
uopForm.sv
decodeTop.sv
tbClock.sv
decodeTb.sv

/* Makefile */
TOOL  = verilator
FLAGS = --binary --timing --timescale 1ns/1ps
TOP   = decodeTb
FLIST = build.f

SRCS := $(shell cat $(FLIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
